//--- pc_glue_pkg.sv
package pc_glue_pkg;

   // bus widths of the PC system board
   localparam int IO_ADDR_W  = 10;   // only a9..a0 decoded on the planar
   localparam int MEM_ADDR_W = 20;   // 1 MB address space
   localparam int DATA_W     = 8;
   localparam int PAGE_W     = 4;    // a19..a16 during DMA

   // offsets inside the 8255 block
   localparam logic [1:0] PORT_B_OFS = 2'd1;   // system control
   localparam logic [1:0] PORT_C_OFS = 2'd2;   // status / switches

   // top nibble of the BIOS ROM window
   localparam logic [3:0] ROM_SEGMENT = 4'hF;

   // planar I/O device, numbered by address bits 7:5
   typedef enum logic [2:0] {
      DEV_DMA      = 3'd0,   // 0x00 8237
      DEV_PIC      = 3'd1,   // 0x20 8259
      DEV_TIMER    = 3'd2,   // 0x40 8253
      DEV_PPI      = 3'd3,   // 0x60 8255
      DEV_DMA_PAGE = 3'd4,   // 0x80 page registers
      DEV_NMI_MASK = 3'd5,   // 0xA0 nmi mask
      DEV_NONE     = 3'd7
   } io_dev_t;

   // hold request / acknowledge sequence
   typedef enum logic [2:0] {
      ARB_CPU  = 3'd0,   // processor owns the bus
      ARB_SYNC = 3'd1,   // idle bus seen once
      ARB_HOLD = 3'd2,   // holda given to the 8237
      ARB_AEN  = 3'd3,   // cpu address buffers off
      ARB_DMA  = 3'd4    // dma drives the bus
   } arb_state_t;

endpackage

//--- io_decode.sv
`timescale 1ns/100ps

module io_decode (
   input  logic [pc_glue_pkg::IO_ADDR_W-1:0]  io_addr_i,
   input  logic                               aen_i,
   input  logic [pc_glue_pkg::MEM_ADDR_W-1:0] mem_addr_i,
   input  logic                               memr_n_i,
   input  logic                               dack0_brd_n_i,
   output pc_glue_pkg::io_dev_t               dev_sel_o,
   output logic                               dma_cs_n_o,
   output logic                               pic_cs_n_o,
   output logic                               timer_cs_n_o,
   output logic                               ppi_cs_n_o,
   output logic [7:0]                         rom_cs_n_o,
   output logic                               ram_sel_n_o
);

   logic rom_en;

   // planar devices live below 0x100, nothing decodes during dma
   always_comb begin
      dev_sel_o = pc_glue_pkg::DEV_NONE;
      if (!aen_i && (io_addr_i[9:8] == 2'b00)) begin
         case (io_addr_i[7:5])
            3'd0:    dev_sel_o = pc_glue_pkg::DEV_DMA;
            3'd1:    dev_sel_o = pc_glue_pkg::DEV_PIC;
            3'd2:    dev_sel_o = pc_glue_pkg::DEV_TIMER;
            3'd3:    dev_sel_o = pc_glue_pkg::DEV_PPI;
            3'd4:    dev_sel_o = pc_glue_pkg::DEV_DMA_PAGE;
            3'd5:    dev_sel_o = pc_glue_pkg::DEV_NMI_MASK;
            default: dev_sel_o = pc_glue_pkg::DEV_NONE;   // 0xC0, 0xE0 unused
         endcase
      end
   end

   assign dma_cs_n_o   = (dev_sel_o != pc_glue_pkg::DEV_DMA);
   assign pic_cs_n_o   = (dev_sel_o != pc_glue_pkg::DEV_PIC);
   assign timer_cs_n_o = (dev_sel_o != pc_glue_pkg::DEV_TIMER);
   assign ppi_cs_n_o   = (dev_sel_o != pc_glue_pkg::DEV_PPI);

   // 8 KB rom sockets across F0000-FFFFF, refresh cycles excluded
   assign rom_en = (mem_addr_i[19:16] == pc_glue_pkg::ROM_SEGMENT) &&
                   !memr_n_i && dack0_brd_n_i;

   assign rom_cs_n_o = rom_en ? ~(8'b0000_0001 << mem_addr_i[15:13]) : 8'hFF;

   // first 256 KB is planar ram
   assign ram_sel_n_o = ~(~mem_addr_i[19] & ~mem_addr_i[18] & dack0_brd_n_i);

endmodule

//--- dma_page_reg.sv
`timescale 1ns/100ps

module dma_page_reg (
   input  logic                              clk,
   input  logic                              reset_n,
   input  pc_glue_pkg::io_dev_t              dev_sel_i,
   input  logic                              iow_n_i,
   input  logic [pc_glue_pkg::IO_ADDR_W-1:0] io_addr_i,
   input  logic [pc_glue_pkg::DATA_W-1:0]    data_i,
   input  logic                              dack2_n_i,
   input  logic                              dack3_n_i,
   input  logic                              dma_aen_n_i,
   output logic [pc_glue_pkg::PAGE_W-1:0]    page_o
);

   logic [pc_glue_pkg::PAGE_W-1:0] page_q [4];   // ls670 style 4x4 file
   logic [1:0]                     rd_idx;
   logic                           wr_en;

   assign wr_en = (dev_sel_i == pc_glue_pkg::DEV_DMA_PAGE) && !iow_n_i;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         for (int i = 0; i < 4; i++) begin
            page_q[i] <= '0;
         end
      end else if (wr_en) begin
         page_q[io_addr_i[1:0]] <= data_i[pc_glue_pkg::PAGE_W-1:0];   // low nibble only
      end
   end

   // read address wired straight from the dack lines
   assign rd_idx = {dack2_n_i, dack3_n_i};

   assign page_o = dma_aen_n_i ? '0 : page_q[rd_idx];   // drives a19..a16 in dma

endmodule

//--- nmi_ctrl.sv
`timescale 1ns/100ps

module nmi_ctrl (
   input  logic                           clk,
   input  logic                           reset_n,
   input  pc_glue_pkg::io_dev_t           dev_sel_i,
   input  logic                           iow_n_i,
   input  logic [pc_glue_pkg::DATA_W-1:0] data_i,
   input  logic                           pck_i,
   input  logic                           io_ch_ck_n_i,
   input  logic                           enb_ram_pck_n_i,
   input  logic                           enable_io_ck_n_i,
   output logic                           pck_flag_o,
   output logic                           io_ch_ck_flag_o,
   output logic                           nmi_o
);

   logic mask_q;
   logic pck_q;
   logic io_ch_ck_q;

   // port 0xA0, only d7 matters
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         mask_q <= 1'b0;
      end else if ((dev_sel_i == pc_glue_pkg::DEV_NMI_MASK) && !iow_n_i) begin
         mask_q <= data_i[7];
      end
   end

   // check latches, held clear by their port B enables
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pck_q      <= 1'b0;
         io_ch_ck_q <= 1'b0;
      end else begin
         if (enb_ram_pck_n_i) begin
            pck_q <= 1'b0;
         end else if (pck_i) begin
            pck_q <= 1'b1;   // ram parity error
         end

         if (enable_io_ck_n_i) begin
            io_ch_ck_q <= 1'b0;
         end else if (!io_ch_ck_n_i) begin
            io_ch_ck_q <= 1'b1;   // expansion card error
         end
      end
   end

   assign pck_flag_o      = pck_q;
   assign io_ch_ck_flag_o = io_ch_ck_q;
   assign nmi_o           = mask_q & (pck_q | io_ch_ck_q);

endmodule

//--- sys_ctrl_port.sv
`timescale 1ns/100ps

module sys_ctrl_port (
   input  logic                              clk,
   input  logic                              reset_n,
   input  pc_glue_pkg::io_dev_t              dev_sel_i,
   input  logic                              iow_n_i,
   input  logic                              ior_n_i,
   input  logic [pc_glue_pkg::IO_ADDR_W-1:0] io_addr_i,
   input  logic [pc_glue_pkg::DATA_W-1:0]    data_i,
   input  logic                              timer2_out_i,
   input  logic                              pck_flag_i,
   input  logic                              io_ch_ck_flag_i,
   output logic [pc_glue_pkg::DATA_W-1:0]    rdata_o,
   output logic                              timer2_gate_o,
   output logic                              spkr_o,
   output logic                              enb_ram_pck_n_o,
   output logic                              enable_io_ck_n_o
);

   logic [pc_glue_pkg::DATA_W-1:0] port_b_q;
   logic                           ppi_sel;

   assign ppi_sel = (dev_sel_i == pc_glue_pkg::DEV_PPI);

   // port 0x61
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         port_b_q <= '0;
      end else if (ppi_sel && !iow_n_i && (io_addr_i[1:0] == pc_glue_pkg::PORT_B_OFS)) begin
         port_b_q <= data_i;
      end
   end

   assign timer2_gate_o    = port_b_q[0];
   assign spkr_o           = port_b_q[1] & timer2_out_i;   // speaker data gated by timer 2
   assign enb_ram_pck_n_o  = port_b_q[4];
   assign enable_io_ck_n_o = port_b_q[5];

   // read back of port B and the port C status bits
   always_comb begin
      rdata_o = '0;
      if (ppi_sel && !ior_n_i) begin
         if (io_addr_i[1:0] == pc_glue_pkg::PORT_B_OFS) begin
            rdata_o = port_b_q;
         end else if (io_addr_i[1:0] == pc_glue_pkg::PORT_C_OFS) begin
            rdata_o[7] = pck_flag_i;
            rdata_o[6] = io_ch_ck_flag_i;
            rdata_o[5] = timer2_out_i;
         end
      end
   end

endmodule

//--- bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       hrq_i,
   input  logic [2:0] status_n_i,
   input  logic       lock_n_i,
   output logic       holda_o,
   output logic       aen_o,
   output logic       dma_aen_n_o,
   output logic       dma_wait_n_o
);

   pc_glue_pkg::arb_state_t state_q;
   pc_glue_pkg::arb_state_t state_d;
   logic                    cpu_idle;

   // passive status and no locked instruction
   assign cpu_idle = (&status_n_i) & lock_n_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         pc_glue_pkg::ARB_CPU: begin
            if (hrq_i && cpu_idle) begin
               state_d = pc_glue_pkg::ARB_SYNC;
            end
         end
         pc_glue_pkg::ARB_SYNC: begin
            state_d = hrq_i ? pc_glue_pkg::ARB_HOLD : pc_glue_pkg::ARB_CPU;
         end
         pc_glue_pkg::ARB_HOLD: begin
            state_d = hrq_i ? pc_glue_pkg::ARB_AEN : pc_glue_pkg::ARB_CPU;
         end
         pc_glue_pkg::ARB_AEN: begin
            state_d = hrq_i ? pc_glue_pkg::ARB_DMA : pc_glue_pkg::ARB_CPU;
         end
         pc_glue_pkg::ARB_DMA: begin
            if (!hrq_i) begin
               state_d = pc_glue_pkg::ARB_CPU;   // 8237 done, give bus back
            end
         end
         default: state_d = pc_glue_pkg::ARB_CPU;
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q <= pc_glue_pkg::ARB_CPU;
      end else begin
         state_q <= state_d;
      end
   end

   // outputs straight from the state register
   assign holda_o = (state_q == pc_glue_pkg::ARB_HOLD) ||
                    (state_q == pc_glue_pkg::ARB_AEN)  ||
                    (state_q == pc_glue_pkg::ARB_DMA);

   assign aen_o = (state_q == pc_glue_pkg::ARB_AEN) ||
                  (state_q == pc_glue_pkg::ARB_DMA);

   assign dma_aen_n_o  = (state_q != pc_glue_pkg::ARB_DMA);
   assign dma_wait_n_o = (state_q != pc_glue_pkg::ARB_DMA);   // holds the cpu not ready

endmodule

//--- pc_glue_top.sv
`timescale 1ns/100ps

module pc_glue_top (
   input  logic                               clk,
   input  logic                               reset_n,
   input  logic [pc_glue_pkg::IO_ADDR_W-1:0]  io_addr_i,
   input  logic                               iow_n_i,
   input  logic                               ior_n_i,
   input  logic [pc_glue_pkg::DATA_W-1:0]     data_i,
   input  logic [pc_glue_pkg::MEM_ADDR_W-1:0] mem_addr_i,
   input  logic                               memr_n_i,
   input  logic                               dack0_brd_n_i,
   input  logic                               dack2_n_i,
   input  logic                               dack3_n_i,
   input  logic                               hrq_i,
   input  logic [2:0]                         status_n_i,
   input  logic                               lock_n_i,
   input  logic                               pck_i,
   input  logic                               io_ch_ck_n_i,
   input  logic                               timer2_out_i,
   output logic [pc_glue_pkg::DATA_W-1:0]     rdata_o,
   output logic [pc_glue_pkg::PAGE_W-1:0]     page_o,
   output logic                               dma_cs_n_o,
   output logic                               pic_cs_n_o,
   output logic                               timer_cs_n_o,
   output logic                               ppi_cs_n_o,
   output logic [7:0]                         rom_cs_n_o,
   output logic                               ram_sel_n_o,
   output logic                               holda_o,
   output logic                               aen_o,
   output logic                               dma_aen_n_o,
   output logic                               dma_wait_n_o,
   output logic                               nmi_o,
   output logic                               spkr_o,
   output logic                               timer2_gate_o
);

   pc_glue_pkg::io_dev_t dev_sel;
   logic                 aen;
   logic                 dma_aen_n;
   logic                 enb_ram_pck_n;    // port B bit 4
   logic                 enable_io_ck_n;   // port B bit 5
   logic                 pck_flag;
   logic                 io_ch_ck_flag;

   assign aen_o       = aen;
   assign dma_aen_n_o = dma_aen_n;

   bus_arbiter u_bus_arbiter (
      .clk          (clk),
      .reset_n      (reset_n),
      .hrq_i        (hrq_i),
      .status_n_i   (status_n_i),
      .lock_n_i     (lock_n_i),
      .holda_o      (holda_o),
      .aen_o        (aen),
      .dma_aen_n_o  (dma_aen_n),
      .dma_wait_n_o (dma_wait_n_o)
   );

   io_decode u_io_decode (
      .io_addr_i     (io_addr_i),
      .aen_i         (aen),
      .mem_addr_i    (mem_addr_i),
      .memr_n_i      (memr_n_i),
      .dack0_brd_n_i (dack0_brd_n_i),
      .dev_sel_o     (dev_sel),
      .dma_cs_n_o    (dma_cs_n_o),
      .pic_cs_n_o    (pic_cs_n_o),
      .timer_cs_n_o  (timer_cs_n_o),
      .ppi_cs_n_o    (ppi_cs_n_o),
      .rom_cs_n_o    (rom_cs_n_o),
      .ram_sel_n_o   (ram_sel_n_o)
   );

   dma_page_reg u_dma_page_reg (
      .clk         (clk),
      .reset_n     (reset_n),
      .dev_sel_i   (dev_sel),
      .iow_n_i     (iow_n_i),
      .io_addr_i   (io_addr_i),
      .data_i      (data_i),
      .dack2_n_i   (dack2_n_i),
      .dack3_n_i   (dack3_n_i),
      .dma_aen_n_i (dma_aen_n),
      .page_o      (page_o)
   );

   nmi_ctrl u_nmi_ctrl (
      .clk              (clk),
      .reset_n          (reset_n),
      .dev_sel_i        (dev_sel),
      .iow_n_i          (iow_n_i),
      .data_i           (data_i),
      .pck_i            (pck_i),
      .io_ch_ck_n_i     (io_ch_ck_n_i),
      .enb_ram_pck_n_i  (enb_ram_pck_n),
      .enable_io_ck_n_i (enable_io_ck_n),
      .pck_flag_o       (pck_flag),
      .io_ch_ck_flag_o  (io_ch_ck_flag),
      .nmi_o            (nmi_o)
   );

   sys_ctrl_port u_sys_ctrl_port (
      .clk              (clk),
      .reset_n          (reset_n),
      .dev_sel_i        (dev_sel),
      .iow_n_i          (iow_n_i),
      .ior_n_i          (ior_n_i),
      .io_addr_i        (io_addr_i),
      .data_i           (data_i),
      .timer2_out_i     (timer2_out_i),
      .pck_flag_i       (pck_flag),
      .io_ch_ck_flag_i  (io_ch_ck_flag),
      .rdata_o          (rdata_o),
      .timer2_gate_o    (timer2_gate_o),
      .spkr_o           (spkr_o),
      .enb_ram_pck_n_o  (enb_ram_pck_n),
      .enable_io_ck_n_o (enable_io_ck_n)
   );

endmodule

//--- tb_pc_glue.sv
`timescale 1ns/100ps

module tb_pc_glue;

   logic                               clk;
   logic                               reset_n;
   logic [pc_glue_pkg::IO_ADDR_W-1:0]  io_addr_i;
   logic [pc_glue_pkg::DATA_W-1:0]     data_i;
   logic [pc_glue_pkg::MEM_ADDR_W-1:0] mem_addr_i;
   logic [2:0]                         status_n_i;
   logic                               iow_n_i, ior_n_i, memr_n_i, lock_n_i, hrq_i;
   logic                               dack0_brd_n_i, dack2_n_i, dack3_n_i;
   logic                               pck_i, io_ch_ck_n_i, timer2_out_i;
   logic [pc_glue_pkg::DATA_W-1:0]     rdata_o;
   logic [pc_glue_pkg::PAGE_W-1:0]     page_o;
   logic [7:0]                         rom_cs_n_o;
   logic                               dma_cs_n_o, pic_cs_n_o, timer_cs_n_o, ppi_cs_n_o;
   logic                               ram_sel_n_o, holda_o, aen_o, dma_aen_n_o, dma_wait_n_o;
   logic                               nmi_o, spkr_o, timer2_gate_o;

   logic [31:0] lfsr_q;
   logic [3:0]  page_exp [4];   // expected page entries
   int          err_cnt;

   pc_glue_top uut (.*);

   always #5 clk = ~clk;

   task automatic report_mismatch(input string msg);
      err_cnt++;
      $display("MISMATCH at %0t ns: %s", $time, msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_failure(input string msg);
      err_cnt++;
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping on a timeout");
   endtask

   task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp)
         else report_mismatch($sformatf("%s is %0h, expected %0h", what, got, exp));
   endtask

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #1;   // inputs move just after the edge
   endtask

   task automatic io_write(input logic [9:0] addr, input logic [7:0] d);
      tick();
      io_addr_i = addr;
      data_i    = d;
      ior_n_i   = 1'b1;
      iow_n_i   = 1'b0;
      tick();
      iow_n_i   = 1'b1;
   endtask

   task automatic read_port(input logic [9:0] addr, output logic [7:0] d);
      tick();
      io_addr_i = addr;
      ior_n_i   = 1'b0;
      #2;
      d = rdata_o;
   endtask

   task automatic check_arb(input logic h, input logic a, input logic d, input string when);
      expect_eq(32'(holda_o), 32'(h), {"holda_o ", when});
      expect_eq(32'(aen_o), 32'(a), {"aen_o ", when});
      expect_eq(32'(dma_aen_n_o), 32'(d), {"dma_aen_n_o ", when});
      expect_eq(32'(dma_wait_n_o), 32'(d), {"dma_wait_n_o ", when});
   endtask

   task automatic wait_dma_aen(input logic level, input string what);
      int n;
      n = 0;
      while (dma_aen_n_o !== level) begin
         if (n == 20) begin
            report_failure({"timed out waiting for ", what});
         end
         tick();
         n++;
      end
   endtask

   // ownership order and quiet planar bus during dma
   assert property (@(posedge clk) disable iff (!reset_n) aen_o |-> holda_o)
      else report_mismatch("aen_o high without holda_o");
   assert property (@(posedge clk) disable iff (!reset_n)
                    aen_o |-> (dma_cs_n_o & pic_cs_n_o & timer_cs_n_o & ppi_cs_n_o))
      else report_mismatch("I/O select low while aen_o is high");
   assert property (@(posedge clk) disable iff (!reset_n) dma_aen_n_o |-> (page_o == '0))
      else report_mismatch("page_o driven while dma_aen_n_o is high");

   initial begin
      logic [31:0] r;
      logic [7:0]  exp_rom;
      logic [7:0]  b;
      logic [7:0]  d;
      logic        sel_ok;
      clk = 1'b0;
      reset_n = 1'b0;
      io_addr_i = '0;
      data_i = '0;
      mem_addr_i = '0;
      status_n_i = 3'b111;
      iow_n_i = 1'b1;
      ior_n_i = 1'b1;
      memr_n_i = 1'b1;
      lock_n_i = 1'b1;
      hrq_i = 1'b0;
      dack0_brd_n_i = 1'b1;
      dack2_n_i = 1'b1;
      dack3_n_i = 1'b1;
      pck_i = 1'b0;
      io_ch_ck_n_i = 1'b1;
      timer2_out_i = 1'b0;
      err_cnt = 0;
      lfsr_q = 32'h2fbd4853;
      repeat (3) @(posedge clk);
      #1;
      reset_n = 1'b1;
      check_arb(1'b0, 1'b0, 1'b1, "after reset");
      expect_eq(32'(nmi_o), 0, "nmi_o after reset");

      // io chip selects while the cpu owns the bus
      for (int i = 0; i < 64; i++) begin
         tick();
         rand_bits(11, r);
         io_addr_i = r[9:0];
         if (r[10]) begin
            io_addr_i[9:8] = 2'b00;
         end
         #2;
         expect_eq(32'(aen_o), 0, "aen_o while idle");
         sel_ok = (io_addr_i[9:8] == 2'b00);
         expect_eq(32'(dma_cs_n_o), 32'(!(sel_ok && io_addr_i[7:5] == 3'd0)), "dma_cs_n_o");
         expect_eq(32'(pic_cs_n_o), 32'(!(sel_ok && io_addr_i[7:5] == 3'd1)), "pic_cs_n_o");
         expect_eq(32'(timer_cs_n_o), 32'(!(sel_ok && io_addr_i[7:5] == 3'd2)), "timer_cs_n_o");
         expect_eq(32'(ppi_cs_n_o), 32'(!(sel_ok && io_addr_i[7:5] == 3'd3)), "ppi_cs_n_o");
      end

      // memory decode
      for (int i = 0; i < 64; i++) begin
         tick();
         rand_bits(24, r);
         mem_addr_i = r[19:0];
         if (r[20]) begin
            mem_addr_i[19:16] = pc_glue_pkg::ROM_SEGMENT;
         end
         memr_n_i      = r[21];
         dack0_brd_n_i = r[22] | r[23];   // refresh one time in four
         #2;
         exp_rom = 8'hFF;
         if (mem_addr_i[19:16] == pc_glue_pkg::ROM_SEGMENT && !memr_n_i && dack0_brd_n_i) begin
            exp_rom[mem_addr_i[15:13]] = 1'b0;
         end
         expect_eq(32'(rom_cs_n_o), 32'(exp_rom), "rom_cs_n_o");
         expect_eq(32'(ram_sel_n_o),
                   32'(!(!mem_addr_i[19] && !mem_addr_i[18] && dack0_brd_n_i)), "ram_sel_n_o");
      end

      // arbitration with no grant during a bus cycle or a lock
      tick();
      memr_n_i      = 1'b1;
      dack0_brd_n_i = 1'b1;
      hrq_i         = 1'b1;
      status_n_i    = 3'b100;
      repeat (4) begin
         tick();
         check_arb(1'b0, 1'b0, 1'b1, "during a bus cycle");
      end
      status_n_i = 3'b111;
      lock_n_i   = 1'b0;
      repeat (3) begin
         tick();
         check_arb(1'b0, 1'b0, 1'b1, "with lock_n_i low");
      end
      lock_n_i = 1'b1;
      tick();
      check_arb(1'b0, 1'b0, 1'b1, "after edge 1");
      tick();
      check_arb(1'b1, 1'b0, 1'b1, "after edge 2");
      tick();
      check_arb(1'b1, 1'b1, 1'b1, "after edge 3");
      tick();
      check_arb(1'b1, 1'b1, 1'b0, "after edge 4");
      hrq_i = 1'b0;
      tick();
      check_arb(1'b0, 1'b0, 1'b1, "after hrq_i drop");
      hrq_i = 1'b1;
      tick();
      hrq_i = 1'b0;   // request gone in sync
      tick();
      hrq_i = 1'b1;
      tick();
      check_arb(1'b0, 1'b0, 1'b1, "one edge after a fresh request");
      tick();
      check_arb(1'b1, 1'b0, 1'b1, "two edges after a fresh request");
      hrq_i = 1'b0;
      tick();
      check_arb(1'b0, 1'b0, 1'b1, "after hrq_i drop in hold");

      // page register file
      for (int i = 0; i < 4; i++) begin
         rand_bits(8, r);
         page_exp[i] = r[3:0];
         io_write(10'h080 | 10'(i), r[7:0]);
      end
      expect_eq(32'(page_o), 0, "page_o with the cpu on the bus");
      hrq_i = 1'b1;
      wait_dma_aen(1'b0, "the DMA grant");
      for (int c = 0; c < 4; c++) begin
         rand_bits(10, r);
         io_addr_i = r[9:0];
         dack2_n_i = c[1];
         dack3_n_i = c[0];
         #2;
         expect_eq(32'(page_o), 32'(page_exp[{dack2_n_i, dack3_n_i}]), "page_o in DMA");
         expect_eq(32'({dma_cs_n_o, pic_cs_n_o, timer_cs_n_o, ppi_cs_n_o}), 32'hF,
                   "selects in DMA");
         tick();
      end
      hrq_i     = 1'b0;
      dack2_n_i = 1'b1;
      dack3_n_i = 1'b1;
      io_addr_i = '0;
      wait_dma_aen(1'b1, "the DMA release");
      expect_eq(32'(page_o), 0, "page_o after release");

      // port B write, read back and port C
      rand_bits(8, r);
      b = r[7:0];
      for (int t = 0; t < 4; t++) begin
         io_write(10'h061, b);
         read_port(10'h061, d);
         expect_eq(32'(d), 32'(b), "port B read");
         expect_eq(32'(spkr_o), 32'(b[1] & timer2_out_i), "spkr_o");
         expect_eq(32'(timer2_gate_o), 32'(b[0]), "timer2_gate_o");
         read_port(10'h062, d);
         expect_eq(32'(d), 32'({2'b00, timer2_out_i, 5'b0}), "port C read");
         tick();
         ior_n_i      = 1'b1;
         timer2_out_i = ~timer2_out_i;
         #2;
         expect_eq(32'(rdata_o), 0, "rdata_o with ior_n_i high");
         if (t == 1) begin
            b = ~b;   // every port B bit seen at both levels
         end
      end
      read_port(10'h063, d);
      expect_eq(32'(d), 0, "read of an unused PPI offset");

      // nmi mask and check latches
      io_write(10'h061, 8'h00);
      io_ch_ck_n_i = 1'b0;
      tick();
      io_ch_ck_n_i = 1'b1;
      read_port(10'h062, d);
      expect_eq(32'(d[7:6]), 32'h1, "port C flags after channel check");
      expect_eq(32'(nmi_o), 0, "nmi_o with the mask clear");
      io_write(10'h0A0, 8'h80);
      expect_eq(32'(nmi_o), 1, "nmi_o after mask set");
      io_write(10'h061, 8'h20);   // channel check off
      tick();
      expect_eq(32'(nmi_o), 0, "nmi_o after channel check disable");
      io_write(10'h061, 8'h00);
      pck_i = 1'b1;
      tick();
      pck_i = 1'b0;
      expect_eq(32'(nmi_o), 1, "nmi_o after parity error");
      read_port(10'h062, d);
      expect_eq(32'(d), 32'({2'b10, timer2_out_i, 5'b0}), "port C after parity error");
      io_write(10'h061, 8'h10);   // parity check off
      tick();
      expect_eq(32'(nmi_o), 0, "nmi_o after parity disable");
      pck_i = 1'b1;
      tick();
      pck_i = 1'b0;
      tick();
      expect_eq(32'(nmi_o), 0, "nmi_o on parity while disabled");

      tick();
      if (err_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- filelist.f
pc_glue_pkg.sv
io_decode.sv
dma_page_reg.sv
nmi_ctrl.sv
sys_ctrl_port.sv
bus_arbiter.sv
pc_glue_top.sv
tb_pc_glue.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_pc_glue -f filelist.f -o sim_pc_glue || exit 1
out=$(./obj_dir/sim_pc_glue 2>&1)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && echo "run.sh: passed" || { echo "run.sh: failed"; exit 1; }
